// File: common/icache_pkg.sv
package icache_pkg;

  localparam int ADDR_BITS      = 32;
  localparam int WORD_BITS      = 32;
  localparam int WORDS_PER_LINE = 8;
  localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;
  localparam int NUM_WAYS       = 4;

  // Byte offset within one line.
  localparam int OFFSET_BITS = 5;

  // Word select within one line.
  localparam int WORD_SEL_BITS = OFFSET_BITS - 2;

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [LINE_BITS-1:0] line_t;

  // Tree bits.
  // [2] is the root, 0 points the victim at ways 2/3.
  // [1] picks way 0 or 1.
  // [0] picks way 2 or 3.
  typedef logic [2:0] plru_t;

  typedef logic [NUM_WAYS-1:0] way_mask_t; // One bit per way.

  typedef logic [WORD_SEL_BITS-1:0] word_sel_t;

  // Array index source.
  typedef enum logic
  {
    curr_cpu_address,
    prev_cpu_address
  } address_sel_t;

endpackage : icache_pkg

// File: icache/icache_control.sv
`timescale 1ns/1ps

module icache_control
  import icache_pkg::*;
(
  input  logic         clk,
  input  logic         rst,

  input  logic         mem_read,
  output logic         mem_resp,

  input  logic         pmem_resp,
  output logic         pmem_read,

  input  logic         hit,
  input  way_mask_t    way_hit,
  input  way_mask_t    valid_out,
  input  plru_t        lru_out,

  output way_mask_t    way_load,
  output logic         lru_load,
  output plru_t        lru_datain,
  output address_sel_t address_sel,
  output logic         stall
);

  // START has no request in stage two.
  // HIT compares the request in stage two.
  // MISS waits for the line from memory.
  typedef enum logic [1:0]
  {
    START,
    MISS,
    HIT
  } state_t;

  state_t    state;
  state_t    next_state;
  way_mask_t fill_way;
  plru_t     lru_next;

  // Fill way for the set in stage two.
  always_comb
  begin
    if (!valid_out[0])
      fill_way = 4'b0001;
    else if (!valid_out[1])
      fill_way = 4'b0010;
    else if (!valid_out[2])
      fill_way = 4'b0100;
    else if (!valid_out[3])
      fill_way = 4'b1000;
    else if (!lru_out[2])
    begin
      if (!lru_out[0])
        fill_way = 4'b1000; // Way 3.
      else
        fill_way = 4'b0100; // Way 2.
    end
    else
    begin
      if (!lru_out[1])
        fill_way = 4'b0010; // Way 1.
      else
        fill_way = 4'b0001; // Way 0.
    end
  end

  // Point the tree away from the way just used.
  always_comb
  begin
    lru_next = lru_out;
    if (way_hit[0])
      lru_next = {1'b0, 1'b0, lru_out[0]};
    else if (way_hit[1])
      lru_next = {1'b0, 1'b1, lru_out[0]};
    else if (way_hit[2])
      lru_next = {1'b1, lru_out[1], 1'b0};
    else if (way_hit[3])
      lru_next = {1'b1, lru_out[1], 1'b1};
  end

  always_comb
  begin
    mem_resp    = 1'b0;
    pmem_read   = 1'b0;
    way_load    = '0;
    lru_load    = 1'b0;
    lru_datain  = lru_out;
    address_sel = curr_cpu_address;
    stall       = 1'b0;

    case (state)
      START:
      begin
        // Index the incoming request.
      end

      MISS:
      begin
        address_sel = prev_cpu_address; // Keep reading the missing set.
        stall       = 1'b1;
        pmem_read   = 1'b1;
        if (pmem_resp)
          way_load = fill_way;
      end

      HIT:
      begin
        if (hit)
        begin
          mem_resp   = 1'b1;
          lru_load   = 1'b1;
          lru_datain = lru_next;
        end
        else
        begin
          address_sel = prev_cpu_address; // Hold the missing address.
          stall       = 1'b1;
        end
      end

      default:
      begin
        stall = 1'b1;
      end
    endcase
  end

  always_comb
  begin
    next_state = state;

    case (state)
      START:
      begin
        if (mem_read)
          next_state = HIT;
      end

      MISS:
      begin
        // Arrays need one more read before the new line shows.
        if (pmem_resp)
          next_state = START;
      end

      HIT:
      begin
        if (!hit)
          next_state = MISS;
        else if (!mem_read)
          next_state = START;
      end

      default:
      begin
        next_state = START;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= START;
    else
      state <= next_state;
  end

endmodule : icache_control

// File: icache/icache_datapath.sv
`timescale 1ns/1ps

module icache_datapath
  import icache_pkg::*;
#(
  parameter int NUM_SETS = 8
)
(
  input  logic         clk,
  input  logic         rst,

  input  logic         mem_read,
  input  addr_t        mem_address,
  output word_t        mem_rdata,

  output addr_t        pmem_address,
  input  line_t        pmem_rdata,

  input  way_mask_t    way_load,
  input  logic         lru_load,
  input  plru_t        lru_datain,
  input  address_sel_t address_sel,
  input  logic         stall,

  output logic         hit,
  output way_mask_t    way_hit,
  output way_mask_t    valid_out,
  output plru_t        lru_out
);

  localparam int INDEX_BITS = $clog2(NUM_SETS);
  localparam int TAG_BITS   = ADDR_BITS - OFFSET_BITS - INDEX_BITS;

  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [TAG_BITS-1:0]   tag_t;

  addr_t     s2_addr;
  logic      s2_valid;
  index_t    s2_index;
  tag_t      s2_tag;
  word_sel_t s2_word;
  index_t    read_index;

  logic      valid_rd [NUM_WAYS];
  tag_t      tag_rd [NUM_WAYS];
  line_t     line_rd [NUM_WAYS];
  plru_t     lru_arr [NUM_SETS];
  line_t     hit_line;

  assign s2_index = s2_addr[OFFSET_BITS +: INDEX_BITS];
  assign s2_tag   = s2_addr[ADDR_BITS-1 -: TAG_BITS];
  assign s2_word  = s2_addr[OFFSET_BITS-1:2];

  assign read_index = (address_sel == prev_cpu_address) ? s2_index
                                                       : mem_address[OFFSET_BITS +: INDEX_BITS];

  assign pmem_address = {s2_addr[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

  // Stage two.
  always_ff @(posedge clk)
  begin
    if (rst)
      s2_valid <= 1'b0;
    else if (!stall)
      s2_valid <= mem_read;

    if (!stall)
      s2_addr <= mem_address;
  end

  for (genvar w = 0; w < NUM_WAYS; w++)
  begin : g_way
    logic  valid_arr [NUM_SETS];
    tag_t  tag_arr [NUM_SETS];
    line_t data_arr [NUM_SETS];

    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        for (int s = 0; s < NUM_SETS; s++)
          valid_arr[s] <= 1'b0;
        valid_rd[w] <= 1'b0;
      end
      else
      begin
        if (way_load[w])
          valid_arr[s2_index] <= 1'b1;
        valid_rd[w] <= valid_arr[read_index];
      end
    end

    // Fill writes the tag held in stage two.
    always_ff @(posedge clk)
    begin
      if (way_load[w])
      begin
        tag_arr[s2_index]  <= s2_tag;
        data_arr[s2_index] <= pmem_rdata;
      end
      tag_rd[w]  <= tag_arr[read_index];
      line_rd[w] <= data_arr[read_index];
    end
  end

  // LRU array.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int s = 0; s < NUM_SETS; s++)
        lru_arr[s] <= '0;
      lru_out <= '0;
    end
    else
    begin
      if (lru_load)
        lru_arr[s2_index] <= lru_datain;
      // back-to-back hits to one set see the newest tree
      if (lru_load && (s2_index == read_index))
        lru_out <= lru_datain;
      else
        lru_out <= lru_arr[read_index];
    end
  end

  always_comb
  begin
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      valid_out[w] = valid_rd[w];
      way_hit[w]   = s2_valid && valid_rd[w] && (tag_rd[w] == s2_tag);
    end
    hit = |way_hit;
  end

  // Ways are one-hot on a hit.
  always_comb
  begin
    hit_line = '0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      if (way_hit[w])
        hit_line = hit_line | line_rd[w];
    end
  end

  always_comb
  begin
    mem_rdata = '0;
    for (int i = 0; i < WORDS_PER_LINE; i++)
    begin
      if (s2_word == WORD_SEL_BITS'(i))
        mem_rdata = hit_line[i*WORD_BITS +: WORD_BITS];
    end
  end

endmodule : icache_datapath

// File: src/icache_top.sv
`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
#(
  parameter int NUM_SETS = 8
)
(
  input  logic  clk,
  input  logic  rst,

  input  logic  mem_read,
  input  addr_t mem_address,
  output logic  mem_resp,
  output word_t mem_rdata,

  output logic  pmem_read,
  output addr_t pmem_address,
  input  logic  pmem_resp,
  input  line_t pmem_rdata
);

  logic         hit;
  way_mask_t    way_hit;
  way_mask_t    valid_out;
  plru_t        lru_out;
  way_mask_t    way_load;
  logic         lru_load;
  plru_t        lru_datain;
  address_sel_t address_sel;
  logic         stall;

  icache_control u_control
  (
    .clk         (clk),
    .rst         (rst),
    .mem_read    (mem_read),
    .mem_resp    (mem_resp),
    .pmem_resp   (pmem_resp),
    .pmem_read   (pmem_read),
    .hit         (hit),
    .way_hit     (way_hit),
    .valid_out   (valid_out),
    .lru_out     (lru_out),
    .way_load    (way_load),
    .lru_load    (lru_load),
    .lru_datain  (lru_datain),
    .address_sel (address_sel),
    .stall       (stall)
  );

  icache_datapath #(
    .NUM_SETS (NUM_SETS)
  ) u_datapath
  (
    .clk          (clk),
    .rst          (rst),
    .mem_read     (mem_read),
    .mem_address  (mem_address),
    .mem_rdata    (mem_rdata),
    .pmem_address (pmem_address),
    .pmem_rdata   (pmem_rdata),
    .way_load     (way_load),
    .lru_load     (lru_load),
    .lru_datain   (lru_datain),
    .address_sel  (address_sel),
    .stall        (stall),
    .hit          (hit),
    .way_hit      (way_hit),
    .valid_out    (valid_out),
    .lru_out      (lru_out)
  );

endmodule : icache_top

// File: tests/icache_properties.sv
`timescale 1ns/1ps

module icache_properties
  import icache_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  mem_read,
  input  logic  mem_resp,
  input  logic  pmem_read,
  input  addr_t pmem_address,
  input  logic  pmem_resp
);

  int unsigned fail_count = 0; // Read by the testbench at the end.

  a_pmem_hold: assert property (@(posedge clk) disable iff (rst)
    (pmem_read && !pmem_resp) |=> (pmem_read && $stable(pmem_address)))
  else
  begin
    $error("pmem_read dropped or pmem_address moved before pmem_resp");
    fail_count++;
  end

  a_pmem_drop: assert property (@(posedge clk) disable iff (rst)
    (pmem_read && pmem_resp) |=> !pmem_read)
  else
  begin
    $error("pmem_read still high in the cycle after pmem_resp");
    fail_count++;
  end

  a_resp_needs_read: assert property (@(posedge clk) disable iff (rst)
    mem_resp |-> mem_read)
  else
  begin
    $error("mem_resp high without mem_read");
    fail_count++;
  end

  a_idle_after_reset: assert property (@(posedge clk)
    rst |=> (!mem_resp && !pmem_read))
  else
  begin
    $error("mem_resp or pmem_read high in the cycle after reset");
    fail_count++;
  end

endmodule : icache_properties

// File: tests/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
  import icache_pkg::*;
();

  localparam int    NUM_SETS    = 8;
  localparam int    SET_BITS    = $clog2(NUM_SETS);
  localparam int    CLK_PERIOD  = 8;
  localparam int    MAX_MEM_LAT = 6;
  localparam word_t PATTERN     = 32'h5a3c_96e1;

  logic  clk = 1'b0;
  logic  rst = 1'b1;
  logic  mem_read = 1'b0;
  addr_t mem_address = '0;
  logic  mem_resp;
  word_t mem_rdata;
  logic  pmem_read;
  addr_t pmem_address;
  logic  pmem_resp = 1'b0;
  line_t pmem_rdata = '0;

  addr_t row_addr [$]; // Address, hold-off before it, reset before it.
  int    row_gap [$];
  bit    row_reset [$];

  bit          ref_valid [NUM_SETS][NUM_WAYS];
  logic [31:0] ref_tag [NUM_SETS][NUM_WAYS];
  plru_t       ref_lru [NUM_SETS];

  int    err_data = 0;
  int    err_proto = 0;
  int    exp_misses = 0;
  int    req_count = 0;
  addr_t last_req_addr = '0;
  bit    mem_busy = 1'b0;
  int    lat_left = 0;
  int    mem_lat = 0;
  bit    aborted = 1'b0;

  icache_top #(
    .NUM_SETS (NUM_SETS)
  ) u_icache_top
  (
    .clk          (clk),
    .rst          (rst),
    .mem_read     (mem_read),
    .mem_address  (mem_address),
    .mem_resp     (mem_resp),
    .mem_rdata    (mem_rdata),
    .pmem_read    (pmem_read),
    .pmem_address (pmem_address),
    .pmem_resp    (pmem_resp),
    .pmem_rdata   (pmem_rdata)
  );

  bind icache_top icache_properties u_properties
  (
    .clk          (clk),
    .rst          (rst),
    .mem_read     (mem_read),
    .mem_resp     (mem_resp),
    .pmem_read    (pmem_read),
    .pmem_address (pmem_address),
    .pmem_resp    (pmem_resp)
  );

  initial
  begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic line_t model_line(addr_t line_addr);
    line_t l;
    for (int i = 0; i < WORDS_PER_LINE; i++)
      l[i*WORD_BITS +: WORD_BITS] = (line_addr + addr_t'(4 * i)) ^ PATTERN;
    return l;
  endfunction

  // Physical memory with a random latency of 1 to 6 cycles.
  always @(posedge clk)
  begin
    if (rst)
    begin
      pmem_resp <= 1'b0;
      mem_busy  <= 1'b0;
    end
    else if (pmem_resp)
      pmem_resp <= 1'b0;
    else if (mem_busy)
    begin
      if (lat_left == 1)
      begin
        pmem_resp  <= 1'b1;
        pmem_rdata <= model_line(pmem_address);
        mem_busy   <= 1'b0;
      end
      else
        lat_left <= lat_left - 1;
    end
    else if (pmem_read)
    begin
      req_count     <= req_count + 1;
      last_req_addr <= pmem_address;
      mem_lat = int'($urandom_range(MAX_MEM_LAT, 1));
      if (mem_lat == 1)
      begin
        pmem_resp  <= 1'b1;
        pmem_rdata <= model_line(pmem_address);
      end
      else
      begin
        mem_busy <= 1'b1;
        lat_left <= mem_lat - 1;
      end
    end
  end

  task automatic ref_clear();
    for (int s = 0; s < NUM_SETS; s++)
    begin
      ref_lru[s] = '0;
      for (int w = 0; w < NUM_WAYS; w++)
        ref_valid[s][w] = 1'b0;
    end
  endtask

  function automatic int fill_way_of(int set);
    for (int w = 0; w < NUM_WAYS; w++)
      if (!ref_valid[set][w])
        return w;
    if (!ref_lru[set][2])
      return ref_lru[set][0] ? 2 : 3;
    return ref_lru[set][1] ? 0 : 1;
  endfunction

  // Tree points away from the way just used.
  task automatic touch_way(int set, int way);
    if (way < 2)
    begin
      ref_lru[set][2] = 1'b0;
      ref_lru[set][1] = (way == 1);
    end
    else
    begin
      ref_lru[set][2] = 1'b1;
      ref_lru[set][0] = (way == 3);
    end
  endtask

  task automatic ref_access(input addr_t a, output bit hit);
    int          set;
    logic [31:0] tag;
    int          way;
    set = int'(a[OFFSET_BITS +: SET_BITS]);
    tag = a >> (OFFSET_BITS + SET_BITS);
    hit = 1'b0;
    way = 0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      if (ref_valid[set][w] && ref_tag[set][w] == tag)
      begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit)
    begin
      way = fill_way_of(set);
      ref_valid[set][way] = 1'b1;
      ref_tag[set][way]   = tag;
    end
    touch_way(set, way);
  endtask

  task automatic add_row(addr_t a, int gap, bit do_reset);
    row_addr.push_back(a);
    row_gap.push_back(gap);
    row_reset.push_back(do_reset);
  endtask

  task automatic build_table();
    addr_t a;
    add_row(32'h0000_1000, 2, 1'b0); // Cold misses in sets 0 to 2.
    add_row(32'h0000_1024, 0, 1'b0);
    add_row(32'h0000_1048, 0, 1'b0);
    for (int i = 0; i < WORDS_PER_LINE; i++)
      add_row(32'h0000_1000 + addr_t'(4 * i), 0, 1'b0); // Same-line burst.
    add_row(32'h0000_1024, 0, 1'b0);
    for (int t = 0; t < 5; t++)
      add_row(32'h0000_20c0 + addr_t'(t * 32'h104), 0, 1'b0); // Five tags in set 6.
    for (int t = 0; t < 4; t++)
      add_row(32'h0000_20c0 + addr_t'(t * 32'h100), 0, 1'b0);
    for (int t = 0; t < 4; t++)
      add_row(32'h0000_30a0 + addr_t'(t * 32'h100), 0, 1'b0); // Fill set 5.
    add_row(32'h0000_32a4, 0, 1'b0);
    add_row(32'h0000_30a8, 0, 1'b0);
    add_row(32'h0000_33ac, 0, 1'b0);
    add_row(32'h0000_31b0, 0, 1'b0);
    add_row(32'h0000_34a0, 0, 1'b0); // Conflict miss.
    add_row(32'h0000_31a0, 0, 1'b0);
    add_row(32'h0000_33a0, 0, 1'b0);
    add_row(32'h0000_30a0, 0, 1'b0);
    add_row(32'h0000_32a0, 0, 1'b0);
    add_row(32'h0000_1000, 3, 1'b1); // Reset first.
    add_row(32'h0000_1024, 0, 1'b0);
    add_row(32'h0000_20c0, 0, 1'b0);
    add_row(32'h0000_1004, 0, 1'b0);
    add_row(32'h0000_31a4, 0, 1'b0);
    add_row(32'h0000_1048, 0, 1'b0);
    for (int t = 1; t < 5; t++)
      add_row(32'h0000_20c0 + addr_t'(t * 32'h100), 0, 1'b0); // Rest of set 6.
    for (int t = 0; t < 5; t++)
      add_row(32'h0000_30a0 + addr_t'(t * 32'h100), 0, 1'b0); // Rest of set 5.
    for (int i = 0; i < 40; i++)
    begin
      a = {16'h0, 8'($urandom_range(5, 0)), 3'($urandom), 3'($urandom), 2'b00};
      add_row(a, 0, 1'b0);
    end
  endtask

  initial
  begin
    int unsigned limit;
    #1;
    limit = row_addr.size() * (MAX_MEM_LAT + 12) + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    bit    hit_pred;
    bit    has_next;
    addr_t cur;
    word_t exp_word;
    int    base_req;
    int    i;
    int    prop_fails;
    void'($urandom(32'heb2d));
    build_table();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    ref_clear();
    i = 0;
    while (i < row_addr.size() && !aborted)
    begin
      repeat (row_gap[i]) @(posedge clk); // Bus idle here.
      mem_read    <= 1'b1;
      mem_address <= row_addr[i];
      @(posedge clk); // Capture edge of row i.
      while (!aborted)
      begin
        cur      = row_addr[i];
        exp_word = (cur & ~addr_t'(3)) ^ PATTERN;
        base_req = req_count;
        ref_access(cur, hit_pred);
        has_next = (i + 1 < row_addr.size()) && !row_reset[i + 1];
        if (!hit_pred)
        begin
          exp_misses++;
          do
          begin
            @(posedge clk);
            if (mem_resp)
            begin
              $display("ERR %0t: mem_resp for %h before its line was fetched", $time, cur);
              err_proto++;
              aborted = 1'b1;
            end
          end
          while (!pmem_resp && !aborted);
          if (aborted)
            break;
          @(posedge clk); // Replay edge.
        end
        if (has_next)
          mem_address <= row_addr[i + 1];
        @(posedge clk); // Response edge, also the next capture edge.
        if (!mem_resp)
        begin
          $display("ERR %0t: no mem_resp for %h, expected a %s", $time, cur,
                   hit_pred ? "hit" : "miss");
          err_proto++;
          aborted = 1'b1;
          break;
        end
        if (mem_rdata !== exp_word)
        begin
          $display("ERR %0t: addr %h data %h expected %h", $time, cur, mem_rdata, exp_word);
          err_data++;
        end
        if (req_count - base_req != (hit_pred ? 0 : 1))
        begin
          $display("ERR %0t: addr %h made %0d line reads, expected %0d", $time, cur,
                   req_count - base_req, hit_pred ? 0 : 1);
          err_proto++;
        end
        if (!hit_pred && last_req_addr !== (cur & ~addr_t'(WORDS_PER_LINE * 4 - 1)))
        begin
          $display("ERR %0t: line read at %h for addr %h", $time, last_req_addr, cur);
          err_proto++;
        end
        i++;
        if (!has_next)
          break;
      end
      if (!aborted && i < row_addr.size())
      begin
        rst <= 1'b1;
        @(posedge clk);
        mem_read <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        ref_clear();
      end
    end
    @(posedge clk);
    if (!aborted && req_count != exp_misses)
    begin
      $display("ERR %0t: %0d line reads, expected %0d", $time, req_count, exp_misses);
      err_proto++;
    end
    prop_fails = int'(u_icache_top.u_properties.fail_count);
    $display("Errors: data %0d, protocol %0d, assertions %0d", err_data, err_proto, prop_fails);
    if (err_data + err_proto + prop_fails == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule : icache_tb

// File: icache_top.f
common/icache_pkg.sv
icache/icache_control.sv
icache/icache_datapath.sv
src/icache_top.sv
tests/icache_properties.sv
tests/icache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the icache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module icache_tb -f icache_top.f -o icache_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/icache_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
